//--- design/mxu_pkg.sv
package mxu_pkg;

    // one activation or one weight, signed
    localparam int act_width = 8;

    // partial sums and result elements, signed
    localparam int acc_width = 20;

    // start must be seen in idle and in all three start phases
    localparam int start_hold_cycles = 4;

    // job sequencing in control_unit
    typedef enum logic [3:0] {
        power_up,
        idle,
        start_p1,
        start_p2,
        start_p3,
        load_weights,
        compute,
        flush,
        done
    } ctrl_state_t;

    // address bits for an n-entry table, never below one
    function automatic int addr_bits(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       write,
    input  logic [WIDTH-1:0]           wdata,
    input  logic                       read,
    output logic [WIDTH-1:0]           rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [ptr_w-1:0] wptr;
    logic [ptr_w-1:0] rptr;
    logic             do_write;
    logic             do_read;

    // circular wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // writes to a full queue are dropped
    assign do_write = write && !full;
    assign do_read  = read && !empty;
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(DEPTH));

    // show-ahead head
    assign rdata = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= next_ptr(wptr);
            end
            if (do_read) begin
                rptr <= next_ptr(rptr);
            end
            count <= count + cnt_w'(do_write) - cnt_w'(do_read);
        end
    end

    // consumers must check empty first
    a_no_read_empty: assert property (@(posedge clk) disable iff (!reset) read |-> !empty);

endmodule

//--- design/input_skew.sv
`timescale 1ns/10ps

module input_skew #(
    parameter int ROWS = 3
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic                              valid,
    input  logic [ROWS*mxu_pkg::act_width-1:0] vector,
    output logic [ROWS*mxu_pkg::act_width-1:0] row_act,
    output logic [ROWS-1:0]                   row_valid
);
    import mxu_pkg::*;

    // lane 0 goes straight into the array
    assign row_act[act_width-1:0] = vector[act_width-1:0];
    assign row_valid[0]           = valid;

    // lane r sits r cycles in its own shift chain
    for (genvar r = 1; r < ROWS; r++) begin : g_lane
        logic [act_width-1:0] act_q [r];
        logic [r-1:0]         vld_q;

        always_ff @(posedge clk) begin
            if (enable) begin
                act_q[0] <= vector[r*act_width +: act_width];
                for (int i = 1; i < r; i++) begin
                    act_q[i] <= act_q[i-1];
                end
            end
        end

        // bubbles travel with valid low
        always_ff @(posedge clk) begin
            if (!reset) begin
                vld_q <= '0;
            end else if (enable) begin
                vld_q[0] <= valid;
                for (int i = 1; i < r; i++) begin
                    vld_q[i] <= vld_q[i-1];
                end
            end
        end

        assign row_act[r*act_width +: act_width] = act_q[r-1];
        assign row_valid[r]                      = vld_q[r-1];
    end

endmodule

//--- design/weight_memory.sv
`timescale 1ns/10ps

module weight_memory #(
    parameter int ROWS    = 3,
    parameter int COLUMNS = 3
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    clear,
    input  logic                                    write,
    input  logic [mxu_pkg::addr_bits(ROWS)-1:0]     waddr,
    input  logic [COLUMNS*mxu_pkg::act_width-1:0]   wdata,
    input  logic                                    ce,
    input  logic [mxu_pkg::addr_bits(ROWS)-1:0]     raddr,
    output logic [COLUMNS*mxu_pkg::act_width-1:0]   rdata
);
    import mxu_pkg::*;

    // one entry per array row, COLUMNS weights each
    logic [COLUMNS*act_width-1:0] mem [ROWS];

    // clear wins over a host write in the same cycle
    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < ROWS; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle behind raddr
    always_ff @(posedge clk) begin
        if (ce) begin
            rdata <= mem[raddr];
        end
    end

    a_waddr_range: assert property (@(posedge clk) disable iff (!reset)
        write |-> (waddr < ROWS));

endmodule

//--- design/mac_pe.sv
`timescale 1ns/10ps

module mac_pe (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 enable,
    input  logic                                 load_weight,
    input  logic signed [mxu_pkg::act_width-1:0] weight_in,
    input  logic signed [mxu_pkg::act_width-1:0] act_in,
    input  logic                                 act_valid_in,
    input  logic signed [mxu_pkg::acc_width-1:0] psum_in,
    output logic signed [mxu_pkg::act_width-1:0] act_out,
    output logic                                 act_valid_out,
    output logic signed [mxu_pkg::acc_width-1:0] psum_out
);
    import mxu_pkg::*;

    logic signed [act_width-1:0]   weight_q;
    logic signed [2*act_width-1:0] product;
    logic signed [acc_width-1:0]   contrib;

    // stationary weight, loaded outside compute
    always_ff @(posedge clk) begin
        if (load_weight) begin
            weight_q <= weight_in;
        end
    end

    assign product = act_in * weight_q;
    // bubble adds nothing
    assign contrib = act_valid_in ? acc_width'(product) : acc_width'(0);

    // activation to the right, sum downward
    always_ff @(posedge clk) begin
        if (enable) begin
            act_out  <= act_in;
            psum_out <= psum_in + contrib;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            act_valid_out <= 1'b0;
        end else if (enable) begin
            act_valid_out <= act_valid_in;
        end
    end

endmodule

//--- design/systolic_array.sv
`timescale 1ns/10ps

module systolic_array #(
    parameter int ROWS    = 3,
    parameter int COLUMNS = 3
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enable,
    input  logic                                  load_data,
    input  logic [mxu_pkg::addr_bits(ROWS)-1:0]   load_row,
    input  logic [COLUMNS*mxu_pkg::act_width-1:0] weight_row,
    input  logic [ROWS*mxu_pkg::act_width-1:0]    row_act,
    input  logic [ROWS-1:0]                       row_valid,
    output logic [COLUMNS*mxu_pkg::acc_width-1:0] col_psum,
    output logic [COLUMNS-1:0]                    col_valid
);
    import mxu_pkg::*;

    // horizontal activation links, one extra column on the right edge
    logic signed [act_width-1:0] act_h [ROWS][COLUMNS+1];
    logic                        vld_h [ROWS][COLUMNS+1];
    // vertical partial-sum links, row 0 input is zero
    logic signed [acc_width-1:0] psum_v [ROWS+1][COLUMNS];

    for (genvar r = 0; r < ROWS; r++) begin : g_left
        assign act_h[r][0] = row_act[r*act_width +: act_width];
        assign vld_h[r][0] = row_valid[r];
    end

    for (genvar c = 0; c < COLUMNS; c++) begin : g_edge
        assign psum_v[0][c] = '0;
        // bottom row: sum and its valid leave together
        assign col_psum[c*acc_width +: acc_width] = psum_v[ROWS][c];
        assign col_valid[c]                       = vld_h[ROWS-1][c+1];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLUMNS; c++) begin : g_col
            mac_pe pe_inst (
                .clk           (clk),
                .reset         (reset),
                .enable        (enable),
                .load_weight   (load_data && (load_row == r)),
                .weight_in     (weight_row[c*act_width +: act_width]),
                .act_in        (act_h[r][c]),
                .act_valid_in  (vld_h[r][c]),
                .psum_in       (psum_v[r][c]),
                .act_out       (act_h[r][c+1]),
                .act_valid_out (vld_h[r][c+1]),
                .psum_out      (psum_v[r+1][c])
            );
        end
    end

endmodule

//--- design/control_unit.sv
`timescale 1ns/10ps

module control_unit #(
    parameter int ROWS       = 3,
    parameter int COLUMNS    = 3,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                glb_enable,
    input  logic                                cs_start,
    output logic                                cs_idle,
    output logic                                cs_ready,
    output logic                                cs_done,
    output logic                                wm_reset,
    output logic                                wm_ce,
    output logic [mxu_pkg::addr_bits(ROWS)-1:0] wm_address,
    output logic                                load_data,
    output logic [mxu_pkg::addr_bits(ROWS)-1:0] load_row,
    input  logic                                infifo_empty,
    output logic                                infifo_read,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]     outfifo_count,
    input  logic                                outfifo_write_seen,
    output logic                                enable_mxu
);
    import mxu_pkg::*;

    localparam int aw    = addr_bits(ROWS);
    localparam int rc_w  = addr_bits(ROWS + 1);
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    ctrl_state_t      state;
    logic [rc_w-1:0]  row_cnt;
    logic [cnt_w-1:0] in_flight;
    logic [cnt_w:0]   credit_sum;
    logic             pop;

    ////////////////////////////////////////////////////////////
    // job FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= power_up;
            row_cnt <= '0;
        end else begin
            case (state)
                // weight memory is cleared here
                power_up: state <= idle;
                idle: begin
                    if (glb_enable && cs_start) begin
                        state <= start_p1;
                    end
                end
                // any low start cycle aborts
                start_p1: state <= cs_start ? start_p2 : idle;
                start_p2: state <= cs_start ? start_p3 : idle;
                start_p3: begin
                    row_cnt <= '0;
                    state   <= cs_start ? load_weights : idle;
                end
                // ROWS reads plus one cycle for the last registered row
                load_weights: begin
                    row_cnt <= row_cnt + 1'b1;
                    if (row_cnt == rc_w'(ROWS)) begin
                        state <= compute;
                    end
                end
                compute: begin
                    if (infifo_empty && (in_flight == '0)) begin
                        state <= flush;
                    end
                end
                flush: state <= done;
                done: state <= idle;
                default: state <= power_up;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // in-flight credits
    ////////////////////////////////////////////////////////////

    // vectors popped whose result is not yet in the output FIFO
    always_ff @(posedge clk) begin
        if (!reset) begin
            in_flight <= '0;
        end else begin
            case ({pop, outfifo_write_seen})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // pop only if every result in flight still fits downstream
    assign credit_sum  = outfifo_count + in_flight;
    assign pop         = (state == compute) && !infifo_empty && (credit_sum < FIFO_DEPTH);
    assign infifo_read = pop;

    // host status decoded from state
    assign cs_idle  = (state == idle);
    assign cs_ready = (state == start_p3) && cs_start;
    assign cs_done  = (state == done);

    // array takes row row_cnt-1 as memory data arrives
    assign wm_reset   = (state == power_up);
    assign wm_ce      = (state == load_weights) && (row_cnt < rc_w'(ROWS));
    assign wm_address = aw'(row_cnt);
    assign load_data  = (state == load_weights) && (row_cnt != '0);
    assign load_row   = aw'(row_cnt - 1'b1);

    assign enable_mxu = (state == compute) || (state == flush);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_ready_done: assert property (@(posedge clk) disable iff (!reset)
        !(cs_ready && cs_done));

    a_credit_bound: assert property (@(posedge clk) disable iff (!reset)
        in_flight <= FIFO_DEPTH);

    // skew, array and deskew together take exactly ROWS+COLUMNS cycles
    a_pipe_latency: assert property (@(posedge clk) disable iff (!reset)
        outfifo_write_seen |-> $past(infifo_read, ROWS + COLUMNS));

endmodule

//--- design/output_deskew.sv
`timescale 1ns/10ps

module output_deskew #(
    parameter int ROWS    = 3,
    parameter int COLUMNS = 3
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enable,
    input  logic [COLUMNS*mxu_pkg::acc_width-1:0] col_psum,
    input  logic [COLUMNS-1:0]                    col_valid,
    output logic [COLUMNS*mxu_pkg::acc_width-1:0] result,
    output logic                                  result_write
);
    import mxu_pkg::*;

    logic [COLUMNS-1:0] lane_vld;

    // a lane must hold the sum of ROWS full-scale products
    if (acc_width < 2 * act_width + $clog2(ROWS)) begin : g_width_check
        $error("accumulator too narrow for %0d rows", ROWS);
    end

    // column c: COLUMNS-1-c alignment stages plus the output register
    for (genvar c = 0; c < COLUMNS; c++) begin : g_col
        localparam int depth = COLUMNS - c;

        logic [acc_width-1:0] sum_q [depth];
        logic [depth-1:0]     vld_q;

        always_ff @(posedge clk) begin
            if (enable) begin
                sum_q[0] <= col_psum[c*acc_width +: acc_width];
                for (int i = 1; i < depth; i++) begin
                    sum_q[i] <= sum_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (!reset) begin
                vld_q <= '0;
            end else if (enable) begin
                vld_q[0] <= col_valid[c];
                for (int i = 1; i < depth; i++) begin
                    vld_q[i] <= vld_q[i-1];
                end
            end
        end

        assign result[c*acc_width +: acc_width] = sum_q[depth-1];
        assign lane_vld[c]                      = vld_q[depth-1];
    end

    // last column arrives last, so it decides the write
    assign result_write = enable && lane_vld[COLUMNS-1];

    a_lanes_aligned: assert property (@(posedge clk) disable iff (!reset)
        result_write |-> (&lane_vld));

endmodule

//--- design/mxu_top.sv
`timescale 1ns/10ps

module mxu_top #(
    parameter int ROWS       = 3,
    parameter int COLUMNS    = 3,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  glb_enable,
    input  logic                                  cs_start,
    output logic                                  cs_idle,
    output logic                                  cs_ready,
    output logic                                  cs_done,
    input  logic                                  wm_write,
    input  logic [mxu_pkg::addr_bits(ROWS)-1:0]   wm_waddr,
    input  logic [COLUMNS*mxu_pkg::act_width-1:0] wm_wdata,
    input  logic                                  in_write,
    input  logic [ROWS*mxu_pkg::act_width-1:0]    in_data,
    output logic                                  in_full,
    input  logic                                  out_read,
    output logic [COLUMNS*mxu_pkg::acc_width-1:0] out_data,
    output logic                                  out_empty
);
    import mxu_pkg::*;

    localparam int aw    = addr_bits(ROWS);
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    // input side
    logic [ROWS*act_width-1:0]    in_head;
    logic                         infifo_empty;
    logic                         infifo_read;
    logic [ROWS*act_width-1:0]    row_act;
    logic [ROWS-1:0]              row_valid;
    // processing part
    logic                         wm_reset;
    logic                         wm_ce;
    logic [aw-1:0]                wm_address;
    logic [COLUMNS*act_width-1:0] weight_row;
    logic                         load_data;
    logic [aw-1:0]                load_row;
    logic                         enable_mxu;
    logic [COLUMNS*acc_width-1:0] col_psum;
    logic [COLUMNS-1:0]           col_valid;
    // output side
    logic [COLUMNS*acc_width-1:0] result;
    logic                         result_write;
    logic [cnt_w-1:0]             outfifo_count;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    sync_fifo #(
        .WIDTH (ROWS * act_width),
        .DEPTH (FIFO_DEPTH)
    ) in_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .write (in_write),
        .wdata (in_data),
        .read  (infifo_read),
        .rdata (in_head),
        .empty (infifo_empty),
        .full  (in_full),
        .count ()
    );

    // popped head enters the skew in the same cycle
    input_skew #(
        .ROWS (ROWS)
    ) input_skew_inst (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable_mxu),
        .valid     (infifo_read),
        .vector    (in_head),
        .row_act   (row_act),
        .row_valid (row_valid)
    );

    ////////////////////////////////////////////////////////////
    // processing part
    ////////////////////////////////////////////////////////////

    control_unit #(
        .ROWS       (ROWS),
        .COLUMNS    (COLUMNS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) control_unit_inst (
        .clk                (clk),
        .reset              (reset),
        .glb_enable         (glb_enable),
        .cs_start           (cs_start),
        .cs_idle            (cs_idle),
        .cs_ready           (cs_ready),
        .cs_done            (cs_done),
        .wm_reset           (wm_reset),
        .wm_ce              (wm_ce),
        .wm_address         (wm_address),
        .load_data          (load_data),
        .load_row           (load_row),
        .infifo_empty       (infifo_empty),
        .infifo_read        (infifo_read),
        .outfifo_count      (outfifo_count),
        .outfifo_write_seen (result_write),
        .enable_mxu         (enable_mxu)
    );

    weight_memory #(
        .ROWS    (ROWS),
        .COLUMNS (COLUMNS)
    ) weight_memory_inst (
        .clk   (clk),
        .reset (reset),
        .clear (wm_reset),
        .write (wm_write),
        .waddr (wm_waddr),
        .wdata (wm_wdata),
        .ce    (wm_ce),
        .raddr (wm_address),
        .rdata (weight_row)
    );

    systolic_array #(
        .ROWS    (ROWS),
        .COLUMNS (COLUMNS)
    ) systolic_array_inst (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable_mxu),
        .load_data  (load_data),
        .load_row   (load_row),
        .weight_row (weight_row),
        .row_act    (row_act),
        .row_valid  (row_valid),
        .col_psum   (col_psum),
        .col_valid  (col_valid)
    );

    ////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////

    output_deskew #(
        .ROWS    (ROWS),
        .COLUMNS (COLUMNS)
    ) output_deskew_inst (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable_mxu),
        .col_psum     (col_psum),
        .col_valid    (col_valid),
        .result       (result),
        .result_write (result_write)
    );

    // credits in control keep this FIFO from overflowing
    sync_fifo #(
        .WIDTH (COLUMNS * acc_width),
        .DEPTH (FIFO_DEPTH)
    ) out_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .write (result_write),
        .wdata (result),
        .read  (out_read),
        .rdata (out_data),
        .empty (out_empty),
        .full  (),
        .count (outfifo_count)
    );

endmodule

//--- dv/mxu_tb.sv
`timescale 1ns/10ps

module mxu_tb;
    import mxu_pkg::*;

    localparam int ROWS       = 3;
    localparam int COLUMNS    = 3;
    localparam int FIFO_DEPTH = 8;
    localparam int aw         = addr_bits(ROWS);
    // reset check job, 6 plain jobs, 4 start tests, 4 stalled jobs
    localparam int num_jobs       = 15;
    localparam int timeout_cycles = num_jobs * (FIFO_DEPTH * 4 + 40);

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         glb_enable;
    logic                         cs_start;
    logic                         cs_idle;
    logic                         cs_ready;
    logic                         cs_done;
    logic                         wm_write;
    logic [aw-1:0]                wm_waddr;
    logic [COLUMNS*act_width-1:0] wm_wdata;
    logic                         in_write = 1'b0;
    logic [ROWS*act_width-1:0]    in_data = '0;
    logic                         in_full;
    logic                         out_read = 1'b0;
    logic [COLUMNS*acc_width-1:0] out_data;
    logic                         out_empty;

    // host copy of the weights which stays zero until the first write
    logic signed [act_width-1:0]  weights [ROWS][COLUMNS];
    logic [ROWS*act_width-1:0]    push_q [$];
    logic [COLUMNS*acc_width-1:0] model_q [$];
    int   error_count;
    int   check_count;
    int   cycle_count;
    int   ready_cnt;
    int   done_cnt;
    int   results_read;
    int   hold_cnt;
    bit   job_active;
    bit   bp_mode;

    mxu_top #(
        .ROWS       (ROWS),
        .COLUMNS    (COLUMNS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) mxu_top_inst (
        .clk        (clk),
        .reset      (reset),
        .glb_enable (glb_enable),
        .cs_start   (cs_start),
        .cs_idle    (cs_idle),
        .cs_ready   (cs_ready),
        .cs_done    (cs_done),
        .wm_write   (wm_write),
        .wm_waddr   (wm_waddr),
        .wm_wdata   (wm_wdata),
        .in_write   (in_write),
        .in_data    (in_data),
        .in_full    (in_full),
        .out_read   (out_read),
        .out_data   (out_data),
        .out_empty  (out_empty)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    // dot product of the vector with each weight column
    function automatic logic [COLUMNS*acc_width-1:0] expected_result(
        input logic [ROWS*act_width-1:0] vec
    );
        logic [COLUMNS*acc_width-1:0] res;
        logic signed [act_width-1:0]  x;
        int                           sum;
        res = '0;
        for (int c = 0; c < COLUMNS; c++) begin
            sum = 0;
            for (int r = 0; r < ROWS; r++) begin
                x   = vec[r*act_width +: act_width];
                sum = sum + int'(x) * int'(weights[r][c]);
            end
            res[c*acc_width +: acc_width] = acc_width'(sum);
        end
        return res;
    endfunction

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("failure at %0t: %s", $time, what);
        end
    endtask

    task automatic check_result(input logic [COLUMNS*acc_width-1:0] got,
                                input logic [COLUMNS*acc_width-1:0] exp);
        check_count++;
        assert (got == exp) else begin
            error_count++;
            $display("** Error out_data: got %h expected %h", got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got == exp) else begin
            error_count++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // host side processes
    ////////////////////////////////////////////////////////////

    // push every other cycle at most, so a write never meets a full FIFO
    always @(posedge clk) begin
        if (reset && push_q.size() > 0 && !in_write && !in_full) begin
            in_data  <= push_q[0];
            in_write <= 1'b1;
            model_q.push_back(expected_result(push_q[0]));
            void'(push_q.pop_front());
        end else begin
            in_write <= 1'b0;
        end
    end

    // reads every other cycle like the writer, with random stalls in bp_mode
    always @(posedge clk) begin
        if (!reset) begin
            out_read <= 1'b0;
            hold_cnt = 0;
        end else if (hold_cnt > 0) begin
            hold_cnt--;
            out_read <= 1'b0;
        end else if (bp_mode && $urandom_range(0, 3) == 0) begin
            hold_cnt = $urandom_range(4, 12);
            out_read <= 1'b0;
        end else begin
            out_read <= !out_read && !out_empty;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            if (cs_ready) begin
                ready_cnt++;
                job_active = 1'b1;
            end
            if (cs_done) begin
                done_cnt++;
                job_active = 1'b0;
            end
            if (job_active) begin
                check_true(!cs_idle, "cs_idle high while a job runs");
            end
            // head is popped at the next rising edge
            if (out_read && !out_empty) begin
                results_read++;
                check_true(ready_cnt == 1, "result without exactly one cs_ready");
                if (model_q.size() == 0) begin
                    check_true(1'b0, "result read with no vector outstanding");
                end else begin
                    check_result(out_data, model_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, a job never completed", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic write_weights();
        logic [COLUMNS*act_width-1:0] row;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLUMNS; c++) begin
                weights[r][c] = act_width'($urandom);
                row[c*act_width +: act_width] = weights[r][c];
            end
            @(posedge clk);
            wm_write <= 1'b1;
            wm_waddr <= aw'(r);
            wm_wdata <= row;
        end
        @(posedge clk);
        wm_write <= 1'b0;
    endtask

    task automatic queue_vectors(input int n);
        logic [ROWS*act_width-1:0] vec;
        for (int i = 0; i < n; i++) begin
            for (int r = 0; r < ROWS; r++) begin
                vec[r*act_width +: act_width] = act_width'($urandom);
            end
            push_q.push_back(vec);
        end
    endtask

    // start held for the given number of edges
    task automatic hold_start(input int cycles);
        @(posedge clk);
        cs_start <= 1'b1;
        repeat (cycles) @(posedge clk);
        cs_start <= 1'b0;
    endtask

    task automatic run_job(input int n, input bit with_stalls);
        results_read = 0;
        ready_cnt    = 0;
        done_cnt     = 0;
        bp_mode      = with_stalls;
        queue_vectors(n);
        // input FIFO full or all vectors in before the job starts
        do @(negedge clk); while (!((in_full || push_q.size() == 0) && !in_write));
        // nothing is popped before the job, so full means FIFO_DEPTH pushes
        compare_bit("in_full", in_full, (n - push_q.size()) >= FIFO_DEPTH);
        hold_start(start_hold_cycles);
        while (done_cnt == 0) @(negedge clk);
        check_true(push_q.size() == 0, "cs_done before all vectors were pushed");
        bp_mode = 1'b0;
        while (results_read < n) @(negedge clk);
        // nothing may show up after the last expected result
        repeat (4) @(negedge clk);
        check_true(out_empty, "extra result after the job");
        check_true(results_read == n, "result count differs from vector count");
        check_true(ready_cnt == 1 && done_cnt == 1, "cs_ready or cs_done count not one");
        check_true(cs_idle, "cs_idle low after the job");
        check_true(model_q.size() == 0, "expected results left over");
    endtask

    task automatic short_start(input int cycles);
        ready_cnt = 0;
        hold_start(cycles);
        repeat (6) @(negedge clk);
        check_true(ready_cnt == 0, "cs_ready after a short start");
        check_true(cs_idle && out_empty, "short start left the unit busy");
    endtask

    task automatic disabled_start();
        ready_cnt = 0;
        @(posedge clk);
        glb_enable <= 1'b0;
        cs_start   <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_true(cs_idle, "start accepted with glb_enable low");
        end
        @(posedge clk);
        cs_start   <= 1'b0;
        glb_enable <= 1'b1;
        repeat (2) @(negedge clk);
        check_true(ready_cnt == 0, "cs_ready with glb_enable low");
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h7a47));
        reset      = 1'b0;
        glb_enable = 1'b0;
        cs_start   = 1'b0;
        wm_write   = 1'b0;
        wm_waddr   = '0;
        wm_wdata   = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLUMNS; c++) begin
                weights[r][c] = '0;
            end
        end
        repeat (2) @(posedge clk);
        reset      <= 1'b1;
        glb_enable <= 1'b1;
        // one power_up cycle, then idle
        @(negedge clk);
        check_true(!cs_ready && !cs_done && out_empty, "outputs active after reset");
        @(negedge clk);
        check_true(cs_idle, "cs_idle low after power_up");

        // weights cleared at power_up, so all-zero results
        run_job(4, 1'b0);
        for (int j = 0; j < 6; j++) begin
            write_weights();
            run_job($urandom_range(1, FIFO_DEPTH), 1'b0);
        end
        for (int k = 1; k < start_hold_cycles; k++) begin
            short_start(k);
        end
        disabled_start();
        // more vectors than the output FIFO holds while the host stalls reads
        for (int j = 0; j < 4; j++) begin
            write_weights();
            run_job($urandom_range(FIFO_DEPTH + 1, FIFO_DEPTH + FIFO_DEPTH / 2), 1'b1);
        end

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
design/mxu_pkg.sv
design/sync_fifo.sv
design/input_skew.sv
design/weight_memory.sv
design/mac_pe.sv
design/systolic_array.sv
design/control_unit.sv
design/output_deskew.sv
design/mxu_top.sv
dv/mxu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module mxu_tb -o mxu_sim

./obj_dir/mxu_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
